//--- verilog/eeprom_pkg.sv
package eeprom_pkg;

    // 2K-byte part, 11-bit byte address
    localparam int EE_ADDR_W = 11;

    // device type code, upper nibble of the control byte
    localparam logic [3:0] EE_DEV_CODE = 4'b1010;

    // bus operations handled by the bit engine
    typedef enum logic [1:0] {
        OP_START, // also repeated start
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] data;    // byte to send on OP_WRITE
        logic       ack_out; // master ack after OP_READ, 1 = nack
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] data;   // byte received on OP_READ
        logic       ack_in; // slave ack after OP_WRITE, 1 = nack
    } bit_rsp_t;

    // transaction sequencer states
    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_e;

endpackage

//--- verilog/eeprom_bit_engine.sv
`timescale 1ns/1ns
module eeprom_bit_engine #(
    parameter int SCL_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 cmd_valid,
    input  logic                 sda_in,
    output eeprom_pkg::bit_rsp_t rsp,
    output logic                 rsp_done,
    output logic                 scl,
    output logic                 sda_low
);

    localparam int HC_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;
    localparam logic [HC_W-1:0] HC_LAST = HC_W'(SCL_DIV - 1);

    eeprom_pkg::bit_op_e op_q;
    logic                ack_out_q;
    logic                active;
    logic [HC_W-1:0]     hcnt;      // CLK cycles within a half period
    logic [4:0]          ph;        // half period within the operation
    logic [7:0]          sh;
    logic                ack_bit;
    logic                done_q;
    logic                scl_q;
    logic                sda_q;
    logic                byte_op;
    logic                half_end;
    logic [4:0]          last_ph;
    logic [3:0]          bit_idx;
    logic                drv_bit;

    assign byte_op  = (op_q == eeprom_pkg::OP_WRITE) || (op_q == eeprom_pkg::OP_READ);
    assign last_ph  = byte_op ? 5'd17 : 5'd3;
    assign half_end = active && (hcnt == HC_LAST);
    assign bit_idx  = ph[4:1]; // even phase = scl low, odd = scl high

    // level to put on sda for the current bit, 1 pulls low
    always_comb
    begin
        if (bit_idx == 4'd8)
            drv_bit = (op_q == eeprom_pkg::OP_READ) ? ~ack_out_q : 1'b0;
        else
            drv_bit = (op_q == eeprom_pkg::OP_WRITE) ? ~sh[7] : 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            hcnt   <= '0;
            ph     <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active <= 1'b1;
                    hcnt   <= '0;
                    ph     <= '0;
                end
            end
            else if (half_end)
            begin
                hcnt <= '0;
                if (ph == last_ph)
                begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
                else
                    ph <= ph + 5'd1;
            end
            else
                hcnt <= hcnt + 1'b1;
        end
    end

    // command latch and shift register
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            op_q      <= cmd.op;
            ack_out_q <= cmd.ack_out;
            sh        <= cmd.data;
        end
        else if (half_end && byte_op && ph[0])
        begin
            // end of high half, sda is stable here
            if (bit_idx == 4'd8)
                ack_bit <= sda_in;
            else
                sh <= {sh[6:0], sda_in};
        end
    end

    // scl and sda drivers
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_valid)
            begin
                case (cmd.op)
                    eeprom_pkg::OP_START: sda_q <= 1'b0; // release first
                    eeprom_pkg::OP_STOP:  sda_q <= 1'b1; // scl is low here
                    default:              scl_q <= 1'b0;
                endcase
            end
        end
        else if (byte_op)
        begin
            // data moves one cycle into the low half
            if (!ph[0] && hcnt == '0)
                sda_q <= drv_bit;
            if (half_end)
                scl_q <= ~ph[0];
        end
        else if (half_end)
        begin
            case (ph[1:0])
                2'd0: scl_q <= 1'b1;
                2'd1: sda_q <= (op_q == eeprom_pkg::OP_START); // start or stop edge
                2'd2:
                begin
                    if (op_q == eeprom_pkg::OP_START)
                        scl_q <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign rsp      = '{data: sh, ack_in: ack_bit};
    assign rsp_done = done_q;
    assign scl      = scl_q;
    assign sda_low  = sda_q;

endmodule

//--- verilog/eeprom_sequencer.sv
`timescale 1ns/1ns
module eeprom_sequencer (
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               wr,
    input  logic                               rd,
    input  logic [eeprom_pkg::EE_ADDR_W-1:0]   addr,
    input  logic [7:0]                         wdata,
    input  eeprom_pkg::bit_rsp_t               rsp,
    input  logic                               rsp_done,
    output eeprom_pkg::bit_cmd_t               cmd,
    output logic                               cmd_valid,
    output logic [7:0]                         rdata,
    output logic                               ack,
    output logic                               nack,
    output logic                               busy
);

    eeprom_pkg::seq_state_e               state;
    eeprom_pkg::seq_state_e               state_nxt;
    eeprom_pkg::bit_cmd_t                 cmd_q;
    logic                                 cmd_valid_q;
    logic                                 is_rd;
    logic [eeprom_pkg::EE_ADDR_W-1:0]     addr_q;
    logic [7:0]                           wdata_q;
    logic [7:0]                           rd_byte;
    logic [7:0]                           rdata_q;
    logic                                 nack_run; // nack seen in this transaction
    logic                                 nack_q;
    logic                                 ack_slot;
    logic                                 accept;

    // bus command issued on entry to each state
    function automatic eeprom_pkg::bit_cmd_t make_cmd(
        input eeprom_pkg::seq_state_e           st,
        input logic [eeprom_pkg::EE_ADDR_W-1:0] a,
        input logic [7:0]                       d
    );
        eeprom_pkg::bit_cmd_t c;
        c.op      = eeprom_pkg::OP_STOP;
        c.data    = 8'h00;
        c.ack_out = 1'b1; // single byte read always ends with nack
        case (st)
            eeprom_pkg::S_START,
            eeprom_pkg::S_RESTART:
                c.op = eeprom_pkg::OP_START;
            eeprom_pkg::S_CTRL_W:
            begin
                c.op   = eeprom_pkg::OP_WRITE;
                c.data = {eeprom_pkg::EE_DEV_CODE, a[eeprom_pkg::EE_ADDR_W-1 -: 3], 1'b0};
            end
            eeprom_pkg::S_ADDR:
            begin
                c.op   = eeprom_pkg::OP_WRITE;
                c.data = a[7:0];
            end
            eeprom_pkg::S_DATA_W:
            begin
                c.op   = eeprom_pkg::OP_WRITE;
                c.data = d;
            end
            eeprom_pkg::S_CTRL_R:
            begin
                c.op   = eeprom_pkg::OP_WRITE;
                c.data = {eeprom_pkg::EE_DEV_CODE, a[eeprom_pkg::EE_ADDR_W-1 -: 3], 1'b1};
            end
            eeprom_pkg::S_DATA_R:
                c.op = eeprom_pkg::OP_READ;
            default: ;
        endcase
        return c;
    endfunction

    assign accept   = (state == eeprom_pkg::S_IDLE) && (wr || rd);
    assign ack_slot = state inside {eeprom_pkg::S_CTRL_W, eeprom_pkg::S_ADDR,
                                    eeprom_pkg::S_DATA_W, eeprom_pkg::S_CTRL_R};

    // where to go when the current bus operation finishes
    always_comb
    begin
        state_nxt = state;
        case (state)
            eeprom_pkg::S_START:   state_nxt = eeprom_pkg::S_CTRL_W;
            eeprom_pkg::S_CTRL_W:
                state_nxt = rsp.ack_in ? eeprom_pkg::S_STOP : eeprom_pkg::S_ADDR;
            eeprom_pkg::S_ADDR:
            begin
                if (rsp.ack_in)
                    state_nxt = eeprom_pkg::S_STOP;
                else if (is_rd)
                    state_nxt = eeprom_pkg::S_RESTART;
                else
                    state_nxt = eeprom_pkg::S_DATA_W;
            end
            eeprom_pkg::S_DATA_W:  state_nxt = eeprom_pkg::S_STOP;
            eeprom_pkg::S_RESTART: state_nxt = eeprom_pkg::S_CTRL_R;
            eeprom_pkg::S_CTRL_R:
                state_nxt = rsp.ack_in ? eeprom_pkg::S_STOP : eeprom_pkg::S_DATA_R;
            eeprom_pkg::S_DATA_R:  state_nxt = eeprom_pkg::S_STOP;
            eeprom_pkg::S_STOP:    state_nxt = eeprom_pkg::S_DONE;
            default:               state_nxt = state;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= eeprom_pkg::S_IDLE;
            cmd_valid_q <= 1'b0;
            nack_run    <= 1'b0;
            nack_q      <= 1'b0;
        end
        else
        begin
            cmd_valid_q <= 1'b0;
            if (accept)
            begin
                state       <= eeprom_pkg::S_START;
                cmd_valid_q <= 1'b1;
                nack_run    <= 1'b0;
            end
            else if (state == eeprom_pkg::S_DONE)
                state <= eeprom_pkg::S_IDLE;
            else if (rsp_done && state != eeprom_pkg::S_IDLE)
            begin
                state <= state_nxt;
                if (state_nxt != eeprom_pkg::S_DONE)
                    cmd_valid_q <= 1'b1;
                if (ack_slot && rsp.ack_in)
                    nack_run <= 1'b1;
                if (state == eeprom_pkg::S_STOP)
                    nack_q <= nack_run; // publish with ack
            end
        end
    end

    // request and data registers
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_rd   <= ~wr; // wr wins
            addr_q  <= addr;
            wdata_q <= wdata;
            cmd_q   <= make_cmd(eeprom_pkg::S_START, addr, wdata);
        end
        else if (rsp_done && state != eeprom_pkg::S_IDLE && state != eeprom_pkg::S_DONE)
        begin
            cmd_q <= make_cmd(state_nxt, addr_q, wdata_q);
            if (state == eeprom_pkg::S_DATA_R)
                rd_byte <= rsp.data;
            if (state == eeprom_pkg::S_STOP && is_rd && !nack_run)
                rdata_q <= rd_byte;
        end
    end

    assign cmd       = cmd_q;
    assign cmd_valid = cmd_valid_q;
    assign rdata     = rdata_q;
    assign ack       = (state == eeprom_pkg::S_DONE);
    assign nack      = nack_q;
    assign busy      = (state != eeprom_pkg::S_IDLE);

endmodule

//--- verilog/eeprom_ctrl_top.sv
`timescale 1ns/1ns
module eeprom_ctrl_top #(
    parameter int SCL_DIV = 4 // CLK cycles per scl half period
) (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::EE_ADDR_W-1:0] addr,
    input  logic [7:0]                       wdata,
    input  logic                             sda_in,
    output logic [7:0]                       rdata,
    output logic                             ack,
    output logic                             nack,
    output logic                             busy,
    output logic                             scl,
    output logic                             sda_low
);

    eeprom_pkg::bit_cmd_t cmd;
    logic                 cmd_valid;
    eeprom_pkg::bit_rsp_t rsp;
    logic                 rsp_done;

    // transaction level
    eeprom_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rsp       (rsp),
        .rsp_done  (rsp_done),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rdata     (rdata),
        .ack       (ack),
        .nack      (nack),
        .busy      (busy)
    );

    // bit level, owns scl and sda
    eeprom_bit_engine #(
        .SCL_DIV (SCL_DIV)
    ) u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sda_in    (sda_in),
        .rsp       (rsp),
        .rsp_done  (rsp_done),
        .scl       (scl),
        .sda_low   (sda_low)
    );

endmodule

//--- dv/eeprom_model.sv
`timescale 1ns/1ns
module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,        // resolved line
    input  logic force_nack, // withhold slave ack
    output logic sda_drive_low,
    output int   err_count
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_RECV,
        M_SEND,
        M_SKIP // nacked, wait for start or stop
    } mode_e;

    localparam int AW = eeprom_pkg::EE_ADDR_W;

    logic [7:0]    mem [0:(1<<AW)-1];
    mode_e         mode;
    logic          scl_p;
    logic          sda_p;
    logic [3:0]    bit_cnt;  // rising scl edges in this byte
    logic [1:0]    byte_idx;
    logic [7:0]    shreg;
    logic [7:0]    out_byte;
    logic [AW-1:0] ptr;
    logic          rd_next;  // control byte asked for a read
    logic          start_seen;
    logic          stop_seen;
    logic          rise;
    logic          fall;

    // lines are oversampled on CLK, edges show up one cycle late
    assign start_seen = scl_p && scl && sda_p && !sda;
    assign stop_seen  = scl_p && scl && !sda_p && sda;
    assign rise       = !scl_p && scl;
    assign fall       = scl_p && !scl;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            mode          <= M_IDLE;
            scl_p         <= 1'b1;
            sda_p         <= 1'b1;
            bit_cnt       <= 4'd0;
            byte_idx      <= 2'd0;
            rd_next       <= 1'b0;
            sda_drive_low <= 1'b0;
            err_count     <= 0;
        end
        else
        begin
            scl_p <= scl;
            sda_p <= sda;
            if (start_seen || stop_seen)
            begin
                // the scl rise of the start or stop itself counts as one bit
                if (mode != M_IDLE && bit_cnt != 4'd1)
                    err_count <= err_count + 1; // sda moved inside a byte
                mode          <= start_seen ? M_RECV : M_IDLE;
                bit_cnt       <= 4'd0;
                byte_idx      <= 2'd0;
                rd_next       <= 1'b0;
                sda_drive_low <= 1'b0;
            end
            else if (mode != M_IDLE && rise)
            begin
                if (bit_cnt < 4'd8)
                    shreg <= {shreg[6:0], sda};
                else if (mode == M_SEND && sda)
                    mode <= M_SKIP; // master nack ends the read
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (mode != M_IDLE && fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    sda_drive_low <= 1'b0;
                    if (mode == M_SEND)
                        ptr <= ptr + AW'(1);
                    else if (mode == M_RECV)
                    begin
                        byte_idx <= byte_idx + 2'd1;
                        case (byte_idx)
                            2'd0:
                            begin
                                if (shreg[7:4] != eeprom_pkg::EE_DEV_CODE)
                                begin
                                    err_count <= err_count + 1;
                                    mode      <= M_SKIP;
                                end
                                else if (force_nack)
                                    mode <= M_SKIP;
                                else
                                begin
                                    sda_drive_low    <= 1'b1;
                                    ptr[AW-1 -: 3]   <= shreg[3:1]; // block select
                                    rd_next          <= shreg[0];
                                end
                            end
                            2'd1:
                            begin
                                if (force_nack)
                                    mode <= M_SKIP;
                                else
                                begin
                                    sda_drive_low <= 1'b1;
                                    ptr[7:0]      <= shreg;
                                end
                            end
                            2'd2:
                            begin
                                if (force_nack)
                                    mode <= M_SKIP;
                                else
                                begin
                                    sda_drive_low <= 1'b1;
                                    mem[ptr]      <= shreg; // no write cycle time
                                end
                            end
                            default: mode <= M_SKIP; // no page writes
                        endcase
                    end
                end
                else if (bit_cnt == 4'd9)
                begin
                    bit_cnt       <= 4'd0;
                    sda_drive_low <= 1'b0;
                    if (mode == M_SEND || (mode == M_RECV && rd_next))
                    begin
                        mode          <= M_SEND;
                        out_byte      <= mem[ptr];
                        sda_drive_low <= ~mem[ptr][7];
                    end
                end
                else if (mode == M_SEND && bit_cnt != 4'd0)
                begin
                    out_byte      <= {out_byte[6:0], 1'b0};
                    sda_drive_low <= ~out_byte[6];
                end
            end
        end
    end

endmodule

//--- dv/tb_eeprom.sv
`timescale 1ns/1ns
module tb_eeprom #(
    parameter int SCL_DIV = 4
);

    localparam int AW          = eeprom_pkg::EE_ADDR_W;
    localparam int NUM_XACT    = 50;
    // seven byte-length operations per transaction plus slack
    localparam int XACT_NS     = (7 * 18 * SCL_DIV + 40) * 10;
    localparam int WATCHDOG_NS = 400 + NUM_XACT * XACT_NS;

    logic          CLK;
    logic          RESET;
    logic          wr;
    logic          rd;
    logic [AW-1:0] addr;
    logic [7:0]    wdata;
    logic [7:0]    rdata;
    logic          ack;
    logic          nack;
    logic          busy;
    logic          scl;
    logic          sda_low;
    logic          sda;
    logic          model_low;
    logic          force_nack;
    int            proto_errs;
    logic [31:0]   lfsr;
    int            err_total;
    int            tests_passed;
    int            tests_failed;
    logic [7:0]    got_data;
    logic          got_nack;
    logic [7:0]    sb_data [0:(1<<AW)-1]; // expected memory contents
    logic [AW-1:0] rnd_addr [0:19];

    assign sda = ~(sda_low | model_low); // pull-up

    always #5 CLK = ~CLK;

    eeprom_ctrl_top #(
        .SCL_DIV (SCL_DIV)
    ) dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .sda_in  (sda),
        .rdata   (rdata),
        .ack     (ack),
        .nack    (nack),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low)
    );

    eeprom_model model0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .force_nack    (force_nack),
        .sda_drive_low (model_low),
        .err_count     (proto_errs)
    );

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, what, exp_v, act_v);
            err_total++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_total == errs_before)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_total - errs_before);
        end
    endtask

    task automatic start_request(input logic is_write, input logic [AW-1:0] a,
                                 input logic [7:0] d);
        @(posedge CLK);
        wr    <= is_write;
        rd    <= ~is_write;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        @(negedge CLK);
        check_val("busy after request", 32'd1, 32'(busy));
    endtask

    task automatic wait_done();
        @(negedge CLK);
        while (ack !== 1'b1)
            @(negedge CLK);
        got_data = rdata;
        got_nack = nack;
    endtask

    task automatic write_checked(input logic [AW-1:0] a, input logic [7:0] d);
        start_request(1'b1, a, d);
        wait_done();
        check_val($sformatf("nack on write to %0h", a), 32'd0, 32'(got_nack));
        sb_data[a] = d;
    endtask

    task automatic read_checked(input logic [AW-1:0] a);
        start_request(1'b0, a, 8'h00);
        wait_done();
        check_val($sformatf("nack on read of %0h", a), 32'd0, 32'(got_nack));
        check_val($sformatf("rdata at %0h", a), 32'(sb_data[a]), 32'(got_data));
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = err_total;
        @(negedge CLK);
        check_val("scl after reset", 32'd1, 32'(scl));
        check_val("sda_low after reset", 32'd0, 32'(sda_low));
        check_val("busy after reset", 32'd0, 32'(busy));
        check_val("ack after reset", 32'd0, 32'(ack));
        check_val("nack after reset", 32'd0, 32'(nack));
        finish_test("reset state", e0);
    endtask

    task automatic test_write_read();
        int e0;
        e0 = err_total;
        write_checked(11'h5a3, 8'hc6);
        read_checked(11'h5a3);
        finish_test("single write and read", e0);
    endtask

    task automatic test_random();
        int          e0;
        logic [31:0] v;
        logic [31:0] d;
        e0 = err_total;
        for (int i = 0; i < 20; i++)
        begin
            take_bits(8, v);
            take_bits(8, d);
            rnd_addr[i] = {i[2:0], v[7:0]}; // walks all eight blocks
            write_checked(rnd_addr[i], d[7:0]);
        end
        for (int i = 0; i < 20; i++)
            read_checked(rnd_addr[(i * 7) % 20]); // stride 7, each once
        check_val("protocol errors", 32'd0, proto_errs);
        finish_test("random addresses", e0);
    endtask

    task automatic test_slave_nack();
        int            e0;
        logic [AW-1:0] a;
        e0 = err_total;
        a  = rnd_addr[0];
        @(posedge CLK);
        force_nack <= 1'b1;
        start_request(1'b1, a, ~sb_data[a]);
        wait_done();
        check_val("nack with slave silent", 32'd1, 32'(got_nack));
        @(posedge CLK);
        force_nack <= 1'b0;
        read_checked(a); // old value survives
        finish_test("slave nack", e0);
    endtask

    task automatic test_busy_strobe();
        int            e0;
        logic [AW-1:0] a;
        logic [AW-1:0] b;
        logic [31:0]   d;
        e0 = err_total;
        a  = rnd_addr[1];
        b  = rnd_addr[2];
        take_bits(8, d);
        start_request(1'b1, a, d[7:0]);
        @(posedge CLK);
        wr    <= 1'b1; // lands mid transaction
        addr  <= b;
        wdata <= ~sb_data[b];
        @(posedge CLK);
        wr <= 1'b0;
        wait_done();
        check_val("nack on busy write", 32'd0, 32'(got_nack));
        sb_data[a] = d[7:0];
        read_checked(b);
        read_checked(a);
        finish_test("strobe while busy", e0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: transactions did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        force_nack   = 1'b0;
        lfsr         = 32'd69101;
        err_total    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        test_reset_state();
        test_write_read();
        test_random();
        test_slave_nack();
        test_busy_strobe();
        check_val("protocol errors at end", 32'd0, proto_errs);
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- compile.f
verilog/eeprom_pkg.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench once per SCL divider
set -e
cd "$(dirname "$0")"

SCL_DIVS="4 2"

for div in $SCL_DIVS
do
    obj="obj_div$div"
    log="sim_div$div.log"
    verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_eeprom \
        -GSCL_DIV="$div" --Mdir "$obj"
    "./$obj/Vtb_eeprom" > "$log" 2>&1
    cat "$log"
    if ! grep -q "Simulation finished: PASS" "$log"
    then
        echo "run with SCL_DIV=$div failed, see $log"
        exit 1
    fi
done
echo "all runs passed"
